// File: hw/dual_issue_pkg.sv
package dual_issue_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    typedef logic [31:0] inst_word_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;

    localparam int DEFAULT_QUEUE_DEPTH = 8;  // Must be a power of two, at least 2.

    //////////////////////////////
    // Encodings
    //////////////////////////////
    localparam opcode_t SPECIAL = 6'b000000;
    localparam opcode_t REGIMM  = 6'b000001;
    localparam opcode_t J       = 6'b000010;
    localparam opcode_t JAL     = 6'b000011;
    localparam opcode_t BEQ     = 6'b000100;
    localparam opcode_t BNE     = 6'b000101;
    localparam opcode_t BLEZ    = 6'b000110;
    localparam opcode_t BGTZ    = 6'b000111;
    localparam opcode_t ADDIU   = 6'b001001;
    localparam opcode_t SLTI    = 6'b001010;
    localparam opcode_t ANDI    = 6'b001100;
    localparam opcode_t ORI     = 6'b001101;
    localparam opcode_t LUI     = 6'b001111;
    localparam opcode_t COP0    = 6'b010000;
    localparam opcode_t LB      = 6'b100000;
    localparam opcode_t LW      = 6'b100011;
    localparam opcode_t LBU     = 6'b100100;
    localparam opcode_t SB      = 6'b101000;
    localparam opcode_t SW      = 6'b101011;

    // Function field of SPECIAL instructions.
    localparam logic [5:0] SLL     = 6'b000000;
    localparam logic [5:0] JR      = 6'b001000;
    localparam logic [5:0] JALR    = 6'b001001;
    localparam logic [5:0] SYSCALL = 6'b001100;
    localparam logic [5:0] BREAK   = 6'b001101;
    localparam logic [5:0] MFHI    = 6'b010000;
    localparam logic [5:0] MFLO    = 6'b010010;
    localparam logic [5:0] MULT    = 6'b011000;
    localparam logic [5:0] MULTU   = 6'b011001;
    localparam logic [5:0] DIV     = 6'b011010;
    localparam logic [5:0] DIVU    = 6'b011011;
    localparam logic [5:0] ADDU    = 6'b100001;
    localparam logic [5:0] SUBU    = 6'b100011;
    localparam logic [5:0] AND     = 6'b100100;
    localparam logic [5:0] OR      = 6'b100101;
    localparam logic [5:0] SLT     = 6'b101010;

    localparam inst_word_t ERET_WORD = 32'h4200_0018;

    //////////////////////////////
    // Records
    //////////////////////////////
    typedef struct packed {
        pc_t        pc;
        inst_word_t word;
    } fetch_entry_t;

    typedef struct packed {
        opcode_t   op;
        reg_addr_t rs;                 // Zero when the field is not read.
        reg_addr_t rt;
        logic      reg_wen;
        reg_addr_t reg_waddr;
        logic      mem_en;
        logic      mem_to_reg;
        logic      is_branch;
        logic      is_spec_inst;
        logic      is_only_in_master;
    } decoded_t;

    typedef struct packed {
        logic      valid;
        logic      mem_to_reg;
        reg_addr_t reg_waddr;
    } exec_rec_t;

    typedef struct packed {
        fetch_entry_t master;
        fetch_entry_t slave;
        logic         slave_valid;
        logic         slave_in_delayslot;
    } issue_bundle_t;

endpackage

// File: hw/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
    parameter int QUEUE_DEPTH = dual_issue_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_valid,
    input  dual_issue_pkg::fetch_entry_t in_entry,
    output logic                         in_ready,
    output dual_issue_pkg::fetch_entry_t head0,
    output dual_issue_pkg::fetch_entry_t head1,
    output logic                         empty,
    output logic                         almost_empty,
    input  logic                         pop_one,
    input  logic                         pop_two
);
    import dual_issue_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    //////////////////////////////
    // Storage and pointers
    //////////////////////////////
    fetch_entry_t mem [QUEUE_DEPTH];

    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    ptr_t       rd_ptr_plus1;
    cnt_t       count;
    logic       push;
    logic [1:0] pop_num;

    // Full only when every slot holds an entry that has not been issued.
    assign in_ready = (count < cnt_t'(QUEUE_DEPTH));
    assign push     = in_valid & in_ready;

    // The issue stage never asks for more entries than are present.
    assign pop_num = pop_two ? 2'd2 : (pop_one ? 2'd1 : 2'd0);

    assign empty        = (count == '0);
    assign almost_empty = (count == cnt_t'(1));

    // The pointer wraps on its own since the depth is a power of two.
    assign rd_ptr_plus1 = rd_ptr + ptr_t'(1);

    // The two oldest entries are always visible since the queue falls through.
    assign head0 = mem[rd_ptr];
    assign head1 = mem[rd_ptr_plus1];  // Stale while fewer than two entries wait.

    //////////////////////////////
    // Write side
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_entry;
        end
    end

    //////////////////////////////
    // Pointer and count update
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            rd_ptr <= rd_ptr + ptr_t'(pop_num);  // Advances by 0, 1 or 2.
            // A push and a pop in the same cycle cancel out in the count.
            count  <= count + cnt_t'(push) - cnt_t'(pop_num);
        end
    end

endmodule

// File: hw/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  dual_issue_pkg::inst_word_t word,
    output dual_issue_pkg::decoded_t   dec
);
    import dual_issue_pkg::*;

    localparam reg_addr_t LINK_REG = 5'd31;

    opcode_t    op;
    logic [5:0] funct;
    reg_addr_t  rs_f;
    reg_addr_t  rt_f;
    reg_addr_t  rd_f;

    assign op    = word[31:26];
    assign rs_f  = word[25:21];
    assign rt_f  = word[20:16];
    assign rd_f  = word[15:11];
    assign funct = word[5:0];

    // Source fields are only reported when the instruction reads them.
    always_comb begin
        dec    = '0;
        dec.op = op;
        case (op)
            SPECIAL: begin
                case (funct)
                    ADDU, SUBU, AND, OR, SLT: begin
                        dec.rs        = rs_f;
                        dec.rt        = rt_f;
                        dec.reg_wen   = 1'b1;
                        dec.reg_waddr = rd_f;
                    end
                    SLL: begin
                        dec.rt        = rt_f;  // A nop lands here with rd zero.
                        dec.reg_wen   = 1'b1;
                        dec.reg_waddr = rd_f;
                    end
                    JR: begin
                        dec.rs        = rs_f;
                        dec.is_branch = 1'b1;
                    end
                    JALR: begin
                        dec.rs        = rs_f;
                        dec.reg_wen   = 1'b1;
                        dec.reg_waddr = rd_f;
                        dec.is_branch = 1'b1;
                    end
                    SYSCALL, BREAK: dec.is_spec_inst = 1'b1;
                    MULT, MULTU, DIV, DIVU: begin
                        dec.rs                = rs_f;
                        dec.rt                = rt_f;
                        dec.is_only_in_master = 1'b1;  // HI/LO unit sits in the master pipe.
                    end
                    MFHI, MFLO: begin
                        dec.reg_wen           = 1'b1;
                        dec.reg_waddr         = rd_f;
                        dec.is_only_in_master = 1'b1;
                    end
                    default: ;
                endcase
            end
            REGIMM: begin
                dec.rs        = rs_f;
                dec.is_branch = 1'b1;
                // The and-link forms set bit 4 of the rt field.
                if (rt_f[4]) begin
                    dec.reg_wen   = 1'b1;
                    dec.reg_waddr = LINK_REG;
                end
            end
            J: dec.is_branch = 1'b1;
            JAL: begin
                dec.is_branch = 1'b1;
                dec.reg_wen   = 1'b1;
                dec.reg_waddr = LINK_REG;
            end
            BEQ, BNE: begin
                dec.rs        = rs_f;
                dec.rt        = rt_f;
                dec.is_branch = 1'b1;
            end
            BLEZ, BGTZ: begin
                dec.rs        = rs_f;
                dec.is_branch = 1'b1;
            end
            ADDIU, SLTI, ANDI, ORI: begin
                dec.rs        = rs_f;
                dec.reg_wen   = 1'b1;
                dec.reg_waddr = rt_f;
            end
            LUI: begin
                dec.reg_wen   = 1'b1;
                dec.reg_waddr = rt_f;
            end
            LW, LB, LBU: begin
                dec.rs         = rs_f;
                dec.reg_wen    = 1'b1;
                dec.reg_waddr  = rt_f;
                dec.mem_en     = 1'b1;
                dec.mem_to_reg = 1'b1;
            end
            SW, SB: begin
                dec.rs     = rs_f;
                dec.rt     = rt_f;  // Store data.
                dec.mem_en = 1'b1;
            end
            COP0: begin
                dec.is_only_in_master = 1'b1;
                if (word == ERET_WORD) begin
                    dec.is_spec_inst = 1'b1;
                end else if (rs_f == 5'b00000) begin  // mfc0 writes rt.
                    dec.reg_wen   = 1'b1;
                    dec.reg_waddr = rt_f;
                end else if (rs_f == 5'b00100) begin  // mtc0 reads rt.
                    dec.rt = rt_f;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: hw/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                      master_en,
    input  dual_issue_pkg::decoded_t  master_dec,
    input  dual_issue_pkg::decoded_t  slave_dec,
    input  dual_issue_pkg::exec_rec_t exec_rec,
    input  logic                      fifo_empty,
    input  logic                      fifo_almost_empty,
    output logic                      slave_en,
    output logic                      slave_in_delayslot
);
    import dual_issue_pkg::*;

    logic      fifo_short;
    logic      load_stall;
    logic      struct_conflict;
    logic      flush_block;
    logic      master_writes;
    reg_addr_t master_dst;

    //////////////////////////////
    // Blocking conditions
    //////////////////////////////

    // A pair needs two words in the queue.
    assign fifo_short = fifo_empty | fifo_almost_empty;

    // Only one memory port exists.
    assign struct_conflict = master_dec.mem_en & slave_dec.mem_en;

    // Branches stay in the master slot, and a special instruction issues alone
    // so that the exception flush never has to split a pair.
    assign flush_block = slave_dec.is_branch | master_dec.is_spec_inst |
                         slave_dec.is_spec_inst;

    // The load issued as master last cycle has no data yet for the slave.
    assign load_stall = exec_rec.valid & exec_rec.mem_to_reg & (|exec_rec.reg_waddr) &
                        (((|slave_dec.rs) & (slave_dec.rs == exec_rec.reg_waddr)) |
                         ((|slave_dec.rt) & (slave_dec.rt == exec_rec.reg_waddr)));

    assign master_dst    = master_dec.reg_waddr;
    assign master_writes = master_dec.reg_wen & (master_dst != '0);

    //////////////////////////////
    // Slave enable
    //////////////////////////////
    always_comb begin
        if (!master_en || fifo_short || load_stall || flush_block ||
            slave_dec.is_only_in_master || struct_conflict) begin
            slave_en = 1'b0;
        end else if (master_writes) begin
            // Both source fields must be nonzero and clear of the master's target.
            slave_en = (|slave_dec.rs) && (slave_dec.rs != master_dst) &&
                       (|slave_dec.rt) && (slave_dec.rt != master_dst);
        end else begin
            slave_en = 1'b1;
        end
    end

    // A slave behind a branch or jump executes as its delay slot.
    assign slave_in_delayslot = master_dec.is_branch & slave_en;

endmodule

// File: hw/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  dual_issue_pkg::fetch_entry_t  head0,
    input  dual_issue_pkg::fetch_entry_t  head1,
    input  logic                          empty,
    input  dual_issue_pkg::decoded_t      master_dec,
    input  logic                          slave_en,
    input  logic                          slave_in_delayslot,
    output logic                          master_en,
    output dual_issue_pkg::exec_rec_t     exec_rec,
    output logic                          issue_valid,
    output dual_issue_pkg::issue_bundle_t issue_bundle,
    input  logic                          issue_ready,
    output logic                          pop_one,
    output logic                          pop_two
);
    import dual_issue_pkg::*;

    logic      accept;
    exec_rec_t exec_nxt;

    //////////////////////////////
    // Issue handshake
    //////////////////////////////

    // Any waiting word can go out as a master on its own.
    assign issue_valid = ~empty;

    // The downstream pipeline accepting this cycle is what lets the master move.
    assign master_en = issue_ready;

    assign accept = issue_valid & issue_ready;

    //////////////////////////////
    // Outgoing bundle
    //////////////////////////////
    always_comb begin
        issue_bundle.master             = head0;
        issue_bundle.slave              = head1;
        issue_bundle.slave_valid        = slave_en;
        issue_bundle.slave_in_delayslot = slave_in_delayslot;
    end

    //////////////////////////////
    // Queue pop
    //////////////////////////////

    // slave_en already implies two entries are present.
    assign pop_two = accept & slave_en;
    assign pop_one = accept & ~slave_en;

    //////////////////////////////
    // Execute-stage record
    //////////////////////////////

    // The record tracks the master that moves to execute on this edge.
    // A cycle without an accepted pair leaves a bubble in execute.
    always_comb begin
        exec_nxt = '0;
        if (accept) begin
            exec_nxt.valid      = 1'b1;
            exec_nxt.mem_to_reg = master_dec.mem_to_reg;
            exec_nxt.reg_waddr  = master_dec.reg_waddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exec_rec <= '0;
        end else begin
            exec_rec <= exec_nxt;  // Bubble clears the record.
        end
    end

endmodule

// File: hw/dual_issue_top.sv
`timescale 1ns/1ps

module dual_issue_top #(
    parameter int QUEUE_DEPTH = dual_issue_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    input  dual_issue_pkg::fetch_entry_t  in_entry,
    output logic                          in_ready,
    output logic                          issue_valid,
    output dual_issue_pkg::issue_bundle_t issue_bundle,
    input  logic                          issue_ready
);
    import dual_issue_pkg::*;

    fetch_entry_t head0;
    fetch_entry_t head1;
    logic         empty;
    logic         almost_empty;
    logic         pop_one;
    logic         pop_two;
    decoded_t     master_dec;
    decoded_t     slave_dec;
    exec_rec_t    exec_rec;
    logic         master_en;
    logic         slave_en;
    logic         slave_in_delayslot;

    inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
        .clk, .reset, .in_valid, .in_entry, .in_ready,
        .head0, .head1, .empty, .almost_empty, .pop_one, .pop_two
    );

    // Master slot decodes the oldest word, slave slot the one behind it.
    inst_decode i_dec_master (.word(head0.word), .dec(master_dec));
    inst_decode i_dec_slave  (.word(head1.word), .dec(slave_dec));

    issue_ctrl i_issue_ctrl (
        .master_en, .master_dec, .slave_dec, .exec_rec,
        .fifo_empty(empty), .fifo_almost_empty(almost_empty),
        .slave_en, .slave_in_delayslot
    );

    issue_stage i_issue_stage (
        .clk, .reset, .head0, .head1, .empty, .master_dec,
        .slave_en, .slave_in_delayslot, .master_en, .exec_rec,
        .issue_valid, .issue_bundle, .issue_ready, .pop_one, .pop_two
    );

endmodule

// File: dv/tb_dual_issue.sv
`timescale 1ns/1ps

module tb_dual_issue;
    import dual_issue_pkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam int NUM_PUSHES  = 3000;
    localparam int CLK_NS      = 20;
    localparam int WATCHDOG_NS = NUM_PUSHES * 4 * CLK_NS;

    // Expected view of one pushed word, filled in when the word is generated.
    typedef struct packed {
        fetch_entry_t entry;
        reg_addr_t    rs;              // Zero when the field is not read.
        reg_addr_t    rt;
        reg_addr_t    waddr;           // Zero when no register is written.
        logic         mem;
        logic         load;
        logic         branch;
        logic         spec;
        logic         only_master;
    } model_inst_t;

    logic          clk;
    logic          reset;
    logic          in_valid;
    fetch_entry_t  in_entry;
    logic          in_ready;
    logic          issue_valid;
    issue_bundle_t issue_bundle;
    logic          issue_ready;

    model_inst_t   model_q[$];
    model_inst_t   cur_inst;
    exec_rec_t     model_exec;
    fetch_entry_t  held_master;
    logic          hold_pending;
    logic          push_fired;
    logic [31:0]   rng_state;
    int            pushes_done;
    int            issued_total;
    int            dual_count;
    int            full_seen;
    int            load_use_seen;
    int            mismatches;
    int            other_errors;

    dual_issue_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_dut (
        .clk, .reset, .in_valid, .in_entry, .in_ready,
        .issue_valid, .issue_bundle, .issue_ready
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (exp === act) else begin
            $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
            mismatches++;
        end
    endtask

    function automatic logic reads_reg(input model_inst_t m, input reg_addr_t r);
        return (r != 5'd0) && ((m.rs == r) || (m.rt == r));
    endfunction

    // Pairing rule for two entries that are both present while the master issues.
    function automatic logic slave_allowed(input model_inst_t m, input model_inst_t s,
                                           input exec_rec_t ex);
        logic hazard;
        logic raw_ok;
        hazard = ex.valid && ex.mem_to_reg && reads_reg(s, ex.reg_waddr);
        raw_ok = 1'b1;
        if (m.waddr != 5'd0) begin
            raw_ok = (s.rs != 5'd0) && (s.rs != m.waddr) && (s.rt != 5'd0) &&
                     (s.rt != m.waddr);
        end
        return !hazard && !s.branch && !m.spec && !s.spec && !s.only_master &&
               !(m.mem && s.mem) && raw_ok;
    endfunction

    // Weighted pool over registers r0 to r3, so that hazards come up often.
    function automatic model_inst_t make_inst(input logic [31:0] r, input pc_t pc);
        model_inst_t m;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  pick;
        rs   = {3'b000, r[9:8]};
        rt   = {3'b000, r[11:10]};
        rd   = {3'b000, r[13:12]};
        pick = r[4:0];
        m    = '0;
        m.entry.pc = pc;
        if (pick <= 5'd6) begin                  // addu
            m.entry.word = {SPECIAL, rs, rt, rd, 5'd0, ADDU};
            m.rs    = rs;
            m.rt    = rt;
            m.waddr = rd;
        end else if (pick <= 5'd10) begin        // addiu
            m.entry.word = {ADDIU, rs, rt, r[31:16]};
            m.rs    = rs;
            m.waddr = rt;
        end else if (pick <= 5'd16) begin        // lw
            m.entry.word = {LW, rs, rt, r[31:16]};
            m.rs    = rs;
            m.waddr = rt;
            m.mem   = 1'b1;
            m.load  = 1'b1;
        end else if (pick <= 5'd19) begin        // sw
            m.entry.word = {SW, rs, rt, r[31:16]};
            m.rs  = rs;
            m.rt  = rt;
            m.mem = 1'b1;
        end else if (pick <= 5'd21) begin        // beq
            m.entry.word = {BEQ, rs, rt, r[31:16]};
            m.rs     = rs;
            m.rt     = rt;
            m.branch = 1'b1;
        end else if (pick <= 5'd23) begin        // jal links to r31
            m.entry.word = {JAL, r[31:6]};
            m.waddr  = 5'd31;
            m.branch = 1'b1;
        end else if (pick <= 5'd25) begin        // mult
            m.entry.word = {SPECIAL, rs, rt, 10'd0, MULT};
            m.rs          = rs;
            m.rt          = rt;
            m.only_master = 1'b1;
        end else if (pick <= 5'd27) begin        // mfhi
            m.entry.word = {SPECIAL, 10'd0, rd, 5'd0, MFHI};
            m.waddr       = rd;
            m.only_master = 1'b1;
        end else if (pick == 5'd28) begin
            m.entry.word = {SPECIAL, 20'd0, SYSCALL};
            m.spec = 1'b1;
        end else if (pick == 5'd29) begin
            m.entry.word  = ERET_WORD;
            m.spec        = 1'b1;
            m.only_master = 1'b1;
        end else begin
            m.entry.word = 32'h0000_0000;        // nop.
        end
        return m;
    endfunction

    //////////////////////////////
    // Monitor and model update
    //////////////////////////////

    // Runs at the falling edge, where every input and output is settled.
    always @(negedge clk) begin : monitor
        logic exp_slave;
        if (reset) begin
            push_fired = 1'b0;
            model_exec = '0;
        end else begin
            exp_slave = 1'b0;
            check_value("issue_valid", 64'(model_q.size() != 0), 64'(issue_valid));
            check_value("in_ready", 64'(model_q.size() < QUEUE_DEPTH), 64'(in_ready));
            if (!in_ready) full_seen++;
            if (model_q.size() != 0) begin
                check_value("issue_bundle.master", model_q[0].entry, issue_bundle.master);
                if (hold_pending) check_value("held master", held_master, issue_bundle.master);
                if (issue_ready && model_q.size() >= 2) begin
                    exp_slave = slave_allowed(model_q[0], model_q[1], model_exec);
                    if (model_exec.valid && model_exec.mem_to_reg &&
                        reads_reg(model_q[1], model_exec.reg_waddr)) begin
                        load_use_seen++;
                        assert (!issue_bundle.slave_valid) else begin
                            $display("Load-use hazard: slave at pc %h issued behind a load",
                                     model_q[1].entry.pc);
                            other_errors++;
                        end
                    end
                end
                check_value("issue_bundle.slave_valid", 64'(exp_slave),
                            64'(issue_bundle.slave_valid));
                if (exp_slave) check_value("issue_bundle.slave", model_q[1].entry,
                                           issue_bundle.slave);
                check_value("issue_bundle.slave_in_delayslot",
                            64'(exp_slave && model_q[0].branch),
                            64'(issue_bundle.slave_in_delayslot));
            end
            // Entries the DUT hands out, counted from its own handshake.
            if (issue_valid && issue_ready) begin
                issued_total += issue_bundle.slave_valid ? 2 : 1;
            end
            hold_pending = issue_valid && !issue_ready;
            held_master  = issue_bundle.master;
            model_exec   = '0;
            if (issue_valid && issue_ready && model_q.size() != 0) begin
                model_exec = '{valid: 1'b1, mem_to_reg: model_q[0].load,
                               reg_waddr: model_q[0].waddr};
                void'(model_q.pop_front());
                if (exp_slave) begin
                    void'(model_q.pop_front());
                    dual_count++;
                end
            end
            push_fired = in_valid && in_ready;
            if (push_fired) model_q.push_back(cur_inst);
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin : stimulus
        int          stall_left;
        logic [31:0] r;
        pc_t         pc;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_entry     = '0;
        issue_ready  = 1'b0;
        cur_inst     = '0;
        model_exec   = '0;
        hold_pending = 1'b0;
        push_fired   = 1'b0;
        rng_state    = 32'hbba98777;
        pc           = 32'h0040_0000;
        stall_left   = 0;
        pushes_done  = 0;
        issued_total = 0;
        dual_count   = 0;
        full_seen    = 0;
        load_use_seen = 0;
        mismatches   = 0;
        other_errors = 0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        check_value("issue_valid after reset", 64'd0, 64'(issue_valid));
        check_value("in_ready after reset", 64'd1, 64'(in_ready));
        while (pushes_done < NUM_PUSHES || model_q.size() != 0) begin
            @(posedge clk);
            #2;
            if (push_fired) begin
                pushes_done++;
                in_valid = 1'b0;
            end
            r = next_rand();
            if (!in_valid && pushes_done < NUM_PUSHES && r[1:0] != 2'b00) begin
                cur_inst = make_inst(next_rand(), pc);
                in_entry = cur_inst.entry;
                in_valid = 1'b1;
                pc       = pc + 32'd4;
            end
            // Mostly ready, with an occasional long stall that fills the queue.
            if (stall_left != 0) begin
                issue_ready = 1'b0;
                stall_left--;
            end else if (r[8:3] == 6'd0) begin
                issue_ready = 1'b0;
                stall_left  = 6 + int'(r[15:12]);
            end else begin
                issue_ready = (r[11:9] != 3'b000);
            end
        end
        repeat (2) @(posedge clk);
        check_value("issued entry count", 64'(NUM_PUSHES), 64'(issued_total));
        if (full_seen == 0) begin
            $display("Stimulus never filled the queue, so back-pressure was not exercised");
            other_errors++;
        end
        if (load_use_seen == 0) begin
            $display("Stimulus never produced a load-use pair");
            other_errors++;
        end
        $display("Errors: %0d mismatches, %0d other failures (%0d pairs dual-issued)",
                 mismatches, other_errors, dual_count);
        if (mismatches + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors + 1);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: list.f
hw/dual_issue_pkg.sv
hw/inst_queue.sv
hw/inst_decode.sv
hw/issue_ctrl.sv
hw/issue_stage.sv
hw/dual_issue_top.sv
dv/tb_dual_issue.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and set the exit status from the testbench result.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
    --top-module tb_dual_issue -o tb_dual_issue &&
./obj_dir/tb_dual_issue | tee /dev/stderr | grep -x "Testbench passed" > /dev/null &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }
